// File: address_unit.sv
`timescale 1ns/1ps

module address_unit (
	input  logic           clk,
	input  logic           reset,
	input  cpu_pkg::byte_t data_bus,
	input  logic           we_ar0,
	input  logic           we_ar1,
	input  logic           we_pc0,
	input  logic           we_pc1,
	input  logic           pc_inc,
	input  logic           ar_inc,
	input  logic           jump,
	input  logic           amid_ar,
	output cpu_pkg::addr_t pc,
	output cpu_pkg::addr_t ar,
	output cpu_pkg::addr_t address
);

	// Program counter
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else if (jump) begin
			pc <= ar; // Taken compare
		end else if (we_pc0 || we_pc1) begin
			if (we_pc0)
				pc[7:0] <= data_bus;
			if (we_pc1)
				pc[15:8] <= data_bus;
		end else if (pc_inc) begin
			pc <= pc + 16'd1;
		end
	end

	// Address register, byte loads beat INC_AR
	always_ff @(posedge clk) begin
		if (reset) begin
			ar <= '0;
		end else if (we_ar0 || we_ar1) begin
			if (we_ar0)
				ar[7:0] <= data_bus;
			if (we_ar1)
				ar[15:8] <= data_bus;
		end else if (ar_inc) begin
			ar <= ar + 16'd1; // Carries into the high byte
		end
	end

	assign address = amid_ar ? ar : pc;

endmodule

// File: bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
	input  cpu_pkg::slot_t mid,
	input  cpu_pkg::slot_t sid,
	input  logic           xfer_en,
	input  cpu_pkg::byte_t ir,
	input  cpu_pkg::byte_t a,
	input  cpu_pkg::byte_t b,
	input  cpu_pkg::byte_t mem_rdata,
	input  cpu_pkg::addr_t pc,
	input  cpu_pkg::addr_t ar,
	output logic           we_ir,
	output logic           we_mem,
	output logic           we_a,
	output logic           we_b,
	output logic           we_ar0,
	output logic           we_ar1,
	output logic           we_pc0,
	output logic           we_pc1,
	output cpu_pkg::byte_t data_bus
);
	import cpu_pkg::*;

	// Slave decode, one-hot while a transfer runs
	assign we_ir  = xfer_en && (sid == SLOT_IR);
	assign we_mem = xfer_en && (sid == SLOT_MEM);
	assign we_a   = xfer_en && (sid == SLOT_A);
	assign we_b   = xfer_en && (sid == SLOT_B);
	assign we_ar0 = xfer_en && (sid == SLOT_AR0);
	assign we_ar1 = xfer_en && (sid == SLOT_AR1);
	assign we_pc0 = xfer_en && (sid == SLOT_PC0);
	assign we_pc1 = xfer_en && (sid == SLOT_PC1);

	// Master source select
	always_comb begin
		case (mid)
			SLOT_IR:  data_bus = ir;
			SLOT_MEM: data_bus = mem_rdata;
			SLOT_A:   data_bus = a;
			SLOT_B:   data_bus = b;
			SLOT_AR0: data_bus = ar[7:0];
			SLOT_AR1: data_bus = ar[15:8];
			SLOT_PC0: data_bus = pc[7:0];
			default:  data_bus = pc[15:8]; // SLOT_PC1
		endcase
	end

endmodule

// File: compile.f
cpu_pkg.sv
control_unit.sv
datapath.sv
address_unit.sv
bus_arbiter.sv
memory_io.sv
cpu_top.sv
tb_cpu.sv

// File: control_unit.sv
`timescale 1ns/1ps

module control_unit (
	input  logic            clk,
	input  logic            reset,
	input  cpu_pkg::byte_t  ir,
	input  cpu_pkg::flags_t flags,
	output cpu_pkg::slot_t  mid,
	output cpu_pkg::slot_t  sid,
	output logic            xfer_en,
	output logic            pc_inc,
	output logic            ar_inc,
	output logic            jump,
	output logic            alu_en,
	output logic            amid_ar,
	output logic            halted
);
	import cpu_pkg::*;

	t_state_e state, state_next;
	op_type_e op_type;
	slot_t    ir_mid;
	slot_t    ir_sid;
	logic     is_cmp, is_hlt, is_inc_ar;
	logic     cmp_pass;

	// Instruction decode
	assign op_type   = op_type_e'(ir[TYPE_HI:TYPE_LO]);
	assign ir_mid    = ir[MID_HI:MID_LO];
	assign ir_sid    = ir[SID_HI:SID_LO];
	assign is_cmp    = (op_type == OP_OTHER) && ir[CMP_BIT];
	assign is_hlt    = (op_type == OP_OTHER) && !ir[CMP_BIT] && (ir[SYS_HI:SYS_LO] == SYS_HLT);
	assign is_inc_ar = (op_type == OP_OTHER) && !ir[CMP_BIT] &&
		(ir[SYS_HI:SYS_LO] == SYS_INC_AR);

	// Selected flag, optionally inverted
	assign cmp_pass = flags[ir[FSEL_HI:FSEL_LO]] ^ ir[FLIP_BIT];

	// Timer sequencing
	always_comb begin
		state_next = state;
		case (state)
			T0: state_next = T1;
			T1: begin
				if (is_hlt)
					state_next = T1; // Park here
				else if (is_cmp && cmp_pass)
					state_next = T2; // Extra cycle for the jump
				else
					state_next = T0;
			end
			default: state_next = T0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state  <= T0;
			halted <= 1'b0;
		end else begin
			if (!halted)
				state <= state_next;
			if (state == T1 && is_hlt)
				halted <= 1'b1; // Sticky until reset
		end
	end

	// Per-state bus and strobe control
	always_comb begin
		mid     = SLOT_MEM; // Fetch source by default
		sid     = SLOT_IR;
		xfer_en = 1'b0;
		pc_inc  = 1'b0;
		ar_inc  = 1'b0;
		jump    = 1'b0;
		alu_en  = 1'b0;
		amid_ar = 1'b0;
		case (state)
			T0: begin
				xfer_en = 1'b1; // Opcode fetch from PC
				pc_inc  = 1'b1;
			end
			T1: begin
				case (op_type)
					OP_MOV: begin
						mid     = ir_mid;
						sid     = ir_sid;
						xfer_en = 1'b1;
						amid_ar = (ir_mid == SLOT_MEM) || (ir_sid == SLOT_MEM); // Mem side uses AR
					end
					OP_MVI: begin
						sid     = ir_sid; // Immediate byte at PC
						xfer_en = 1'b1;
						pc_inc  = 1'b1;
					end
					OP_ALU:  alu_en = 1'b1;
					default: ar_inc = is_inc_ar;
				endcase
			end
			T2:      jump = 1'b1; // PC <= AR
			default: ;
		endcase
	end

endmodule

// File: cpu_pkg.sv
package cpu_pkg;

	// Data and address widths
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] addr_t;
	typedef logic [2:0]  slot_t;
	typedef logic [3:0]  flags_t; // {sign, zero, parity, carry}

	// Data bus slot IDs, same map for master and slave
	localparam slot_t SLOT_IR  = 3'd0;
	localparam slot_t SLOT_MEM = 3'd1;
	localparam slot_t SLOT_A   = 3'd2;
	localparam slot_t SLOT_B   = 3'd3;
	localparam slot_t SLOT_AR0 = 3'd4; // AR low byte
	localparam slot_t SLOT_AR1 = 3'd5; // AR high byte
	localparam slot_t SLOT_PC0 = 3'd6;
	localparam slot_t SLOT_PC1 = 3'd7;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
		ALU_XOR, ALU_NOT, ALU_INC, ALU_DEC
	} alu_op_e;

	// Instruction class from bits 7:6
	typedef enum logic [1:0] {OP_MOV, OP_MVI, OP_ALU, OP_OTHER} op_type_e;

	typedef enum logic [1:0] {T0, T1, T2} t_state_e;

	// Opcode field positions
	localparam int TYPE_HI  = 7;
	localparam int TYPE_LO  = 6;
	localparam int MID_HI   = 5;
	localparam int MID_LO   = 3;
	localparam int SID_HI   = 2;
	localparam int SID_LO   = 0;
	localparam int ALU_HI   = 2;
	localparam int ALU_LO   = 0;
	localparam int CMP_BIT  = 5; // Compare-jump when set in OP_OTHER
	localparam int FSEL_HI  = 4;
	localparam int FSEL_LO  = 3;
	localparam int FLIP_BIT = 2;
	localparam int SYS_HI   = 2;
	localparam int SYS_LO   = 0;

	localparam logic [2:0] SYS_HLT    = 3'b001;
	localparam logic [2:0] SYS_INC_AR = 3'b010;

	localparam int PORT_BIT          = 15; // Output port select
	localparam int MEM_DEPTH_DEFAULT = 256;

endpackage

// File: cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
	parameter int MEM_DEPTH = cpu_pkg::MEM_DEPTH_DEFAULT
) (
	input  logic           clk,
	input  logic           reset,
	input  logic           load_we,
	input  cpu_pkg::byte_t load_addr,
	input  cpu_pkg::byte_t load_data,
	output cpu_pkg::byte_t out_port,
	output logic           out_strobe,
	output logic           halted
);
	import cpu_pkg::*;

	// Control strobes
	slot_t  mid, sid;
	logic   xfer_en, pc_inc, ar_inc, jump, alu_en, amid_ar;
	// Slave write enables
	logic   we_ir, we_mem, we_a, we_b, we_ar0, we_ar1, we_pc0, we_pc1;
	// Buses and register values
	byte_t  data_bus, ir, a, b, mem_rdata;
	flags_t flags;
	addr_t  pc, ar, address;

	control_unit u_control (
		.clk(clk), .reset(reset),
		.ir(ir), .flags(flags),
		.mid(mid), .sid(sid), .xfer_en(xfer_en),
		.pc_inc(pc_inc), .ar_inc(ar_inc), .jump(jump),
		.alu_en(alu_en), .amid_ar(amid_ar), .halted(halted)
	);

	datapath u_datapath (
		.clk(clk), .reset(reset), .data_bus(data_bus),
		.we_ir(we_ir), .we_a(we_a), .we_b(we_b), .alu_en(alu_en),
		.ir(ir), .a(a), .b(b), .flags(flags)
	);

	address_unit u_address (
		.clk(clk), .reset(reset), .data_bus(data_bus),
		.we_ar0(we_ar0), .we_ar1(we_ar1), .we_pc0(we_pc0), .we_pc1(we_pc1),
		.pc_inc(pc_inc), .ar_inc(ar_inc), .jump(jump), .amid_ar(amid_ar),
		.pc(pc), .ar(ar), .address(address)
	);

	bus_arbiter u_arbiter (
		.mid(mid), .sid(sid), .xfer_en(xfer_en),
		.ir(ir), .a(a), .b(b), .mem_rdata(mem_rdata), .pc(pc), .ar(ar),
		.we_ir(we_ir), .we_mem(we_mem), .we_a(we_a), .we_b(we_b),
		.we_ar0(we_ar0), .we_ar1(we_ar1), .we_pc0(we_pc0), .we_pc1(we_pc1),
		.data_bus(data_bus)
	);

	memory_io #(.MEM_DEPTH(MEM_DEPTH)) u_memory (
		.clk(clk), .reset(reset),
		.address(address), .data_bus(data_bus), .we_mem(we_mem),
		.load_we(load_we), .load_addr(load_addr), .load_data(load_data),
		.mem_rdata(mem_rdata), .out_port(out_port), .out_strobe(out_strobe)
	);

endmodule

// File: datapath.sv
`timescale 1ns/1ps

module datapath (
	input  logic            clk,
	input  logic            reset,
	input  cpu_pkg::byte_t  data_bus,
	input  logic            we_ir,
	input  logic            we_a,
	input  logic            we_b,
	input  logic            alu_en,
	output cpu_pkg::byte_t  ir,
	output cpu_pkg::byte_t  a,
	output cpu_pkg::byte_t  b,
	output cpu_pkg::flags_t flags
);
	import cpu_pkg::*;

	alu_op_e    alu_op;
	logic [8:0] alu_wide; // Bit 8 is carry or borrow
	byte_t      result;
	flags_t     new_flags;

	assign alu_op = alu_op_e'(ir[ALU_HI:ALU_LO]);

	always_comb begin
		case (alu_op)
			ALU_ADD: alu_wide = {1'b0, a} + {1'b0, b};
			ALU_SUB: alu_wide = {1'b0, a} - {1'b0, b}; // Borrow lands in bit 8
			ALU_AND: alu_wide = {1'b0, a & b};
			ALU_OR:  alu_wide = {1'b0, a | b};
			ALU_XOR: alu_wide = {1'b0, a ^ b};
			ALU_NOT: alu_wide = {1'b0, ~a};
			ALU_INC: alu_wide = {1'b0, a} + 9'd1;
			ALU_DEC: alu_wide = {1'b0, a} - 9'd1;
			default: alu_wide = '0;
		endcase
	end

	assign result = alu_wide[7:0];
	// Sign, zero, odd-ones parity, carry
	assign new_flags = {result[7], result == 8'h00, ^result, alu_wide[8]};

	always_ff @(posedge clk) begin
		if (reset) begin
			ir    <= '0;
			a     <= '0;
			b     <= '0;
			flags <= '0;
		end else begin
			if (we_ir)
				ir <= data_bus;
			if (alu_en) begin
				a     <= result; // ALU wins over bus
				flags <= new_flags;
			end else if (we_a) begin
				a <= data_bus;
			end
			if (we_b)
				b <= data_bus;
		end
	end

endmodule

// File: memory_io.sv
`timescale 1ns/1ps

module memory_io #(
	parameter int MEM_DEPTH = 256
) (
	input  logic           clk,
	input  logic           reset,
	input  cpu_pkg::addr_t address,
	input  cpu_pkg::byte_t data_bus,
	input  logic           we_mem,
	input  logic           load_we,
	input  cpu_pkg::byte_t load_addr,
	input  cpu_pkg::byte_t load_data,
	output cpu_pkg::byte_t mem_rdata,
	output cpu_pkg::byte_t out_port,
	output logic           out_strobe
);
	import cpu_pkg::*;

	localparam int AW = $clog2(MEM_DEPTH);

	byte_t          ram [MEM_DEPTH];
	logic [AW-1:0]  ram_idx;
	logic [AW-1:0]  load_idx;
	logic           port_sel;

	assign ram_idx   = address[AW-1:0];
	assign load_idx  = AW'(load_addr);
	assign port_sel  = address[PORT_BIT]; // Upper half is I/O
	assign mem_rdata = ram[ram_idx]; // Async read

	always_ff @(posedge clk) begin
		if (load_we)
			ram[load_idx] <= load_data; // Program load
		else if (we_mem && !port_sel)
			ram[ram_idx] <= data_bus;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_port   <= '0;
			out_strobe <= 1'b0;
		end else begin
			out_strobe <= we_mem && port_sel; // One-cycle pulse
			if (we_mem && port_sel)
				out_port <= data_bus;
		end
	end

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing --top-module tb_cpu -f compile.f -o tb_cpu

out=$(./obj_dir/tb_cpu 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Test completed successfully"; then
	exit 0
else
	exit 1
fi

// File: tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;
	import cpu_pkg::*;

	logic  clk, reset, load_we, out_strobe, halted;
	byte_t load_addr, load_data, out_port;

	int    seed;
	int    prog;
	int    len;         // Program bytes emitted so far
	int    seen;        // Port writes observed on the DUT
	byte_t img [256];   // Load image
	byte_t m_mem [256]; // Model RAM
	byte_t m_a, m_b;
	addr_t m_ar, m_pc;
	logic [3:0] m_flags; // Sign, zero, parity, carry
	byte_t exp_q [$];    // Expected port writes in order

	cpu_top #(.MEM_DEPTH(MEM_DEPTH_DEFAULT)) UUT (
		.clk(clk), .reset(reset), .load_we(load_we), .load_addr(load_addr),
		.load_data(load_data), .out_port(out_port), .out_strobe(out_strobe), .halted(halted)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic fail_now(input string line);
		$display("%s", line);
		$display("Test failed");
		$fatal(1, "Simulation stopped at first error");
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		assert (expected == actual) else
			fail_now($sformatf("CHECK FAILED %s: expected 0x%0h, actual 0x%0h",
				name, expected, actual));
	endtask

	task automatic require(input logic cond, input string why);
		assert (cond) else fail_now(why);
	endtask

	function automatic int rand_below(input int n);
		int r;
		r = $random(seed);
		return int'($unsigned(r) % n);
	endfunction

	// Only A, B and the AR bytes
	function automatic slot_t pick_reg();
		case (rand_below(4))
			0:       return SLOT_A;
			1:       return SLOT_B;
			2:       return SLOT_AR0;
			default: return SLOT_AR1;
		endcase
	endfunction

	task automatic emit(input byte_t v);
		img[len] = v;
		len++;
	endtask

	task automatic build_program();
		int start;
		for (int i = 0; i < 256; i++)
			img[i] = 8'(i) ^ 8'hc3; // Filler that never runs
		len = 0;
		while (len < 230) begin
			start = len;
			case (rand_below(8))
				0: begin
					emit({2'b01, 3'b000, pick_reg()}); // MVI reg, imm
					emit(8'(rand_below(256)));
				end
				1: emit({2'b00, pick_reg(), pick_reg()});
				2, 3: emit({2'b10, 3'b000, 3'(rand_below(8))});
				4: begin
					emit({2'b01, 3'b000, SLOT_AR1}); // Port page
					emit(8'h80);
					emit({2'b00, SLOT_A, SLOT_MEM});
				end
				5: begin
					emit({2'b01, 3'b000, SLOT_AR1});
					emit(rand_below(2) != 0 ? 8'hff : 8'h7f); // Wrap to RAM or to port
					emit({2'b01, 3'b000, SLOT_AR0});
					emit(8'hff);
					emit(8'hc2); // INC_AR carries into AR1
					emit({2'b00, SLOT_A, SLOT_MEM});
				end
				6: emit(8'hc2);
				default: begin
					emit({2'b01, 3'b000, SLOT_AR0});
					emit(8'(start + 8)); // Past the skipped port write
					emit({2'b01, 3'b000, SLOT_AR1});
					emit(8'h00);
					emit({3'b111, 2'(rand_below(4)), 1'(rand_below(2)), 2'b00});
					emit({2'b01, 3'b000, SLOT_AR1});
					emit(8'h80);
					emit({2'b00, SLOT_A, SLOT_MEM});
				end
			endcase
		end
		emit(8'hc1); // HLT
	endtask

	function automatic byte_t read_slot(input slot_t s, input byte_t op);
		case (s)
			SLOT_IR:  return op;
			SLOT_MEM: return m_mem[m_ar[7:0]];
			SLOT_A:   return m_a;
			SLOT_B:   return m_b;
			SLOT_AR0: return m_ar[7:0];
			SLOT_AR1: return m_ar[15:8];
			SLOT_PC0: return m_pc[7:0];
			default:  return m_pc[15:8];
		endcase
	endfunction

	task automatic write_slot(input slot_t s, input byte_t v, input addr_t maddr);
		case (s)
			SLOT_MEM: begin
				if (maddr[15])
					exp_q.push_back(v); // Output port
				else
					m_mem[maddr[7:0]] = v;
			end
			SLOT_A:   m_a = v;
			SLOT_B:   m_b = v;
			SLOT_AR0: m_ar[7:0] = v;
			SLOT_AR1: m_ar[15:8] = v;
			SLOT_PC0: m_pc[7:0] = v;
			SLOT_PC1: m_pc[15:8] = v;
			default:  ;
		endcase
	endtask

	task automatic alu_step(input logic [2:0] op);
		int    ai, bi, ri;
		logic  c;
		byte_t r;
		ai = int'(m_a);
		bi = int'(m_b);
		c = 1'b0;
		case (op)
			3'd0: begin
				ri = ai + bi;
				c = (ri > 255);
			end
			3'd1: begin
				ri = ai - bi;
				c = (ai < bi); // Borrow
			end
			3'd2: ri = ai & bi;
			3'd3: ri = ai | bi;
			3'd4: ri = ai ^ bi;
			3'd5: ri = 255 - ai;
			3'd6: begin
				ri = ai + 1;
				c = (ai == 255);
			end
			default: begin
				ri = ai - 1;
				c = (ai == 0);
			end
		endcase
		r = 8'(ri);
		m_a = r;
		m_flags[3] = r[7]; // Sign
		m_flags[2] = (r == 8'h00);
		m_flags[1] = (($countones(r) % 2) == 1); // Parity set on odd ones
		m_flags[0] = c;
	endtask

	// One instruction per step on the DUT's load image
	task automatic run_model();
		byte_t op;
		int    steps;
		logic  done;
		m_mem = img;
		m_a = '0;
		m_b = '0;
		m_ar = '0;
		m_pc = '0;
		m_flags = '0;
		exp_q.delete();
		done = 1'b0;
		steps = 0;
		while (!done && steps < 1000) begin
			op = m_mem[m_pc[7:0]];
			m_pc = m_pc + 16'd1;
			case (op[7:6])
				2'b00: write_slot(op[2:0], read_slot(op[5:3], op), m_ar);
				2'b01: begin
					write_slot(op[2:0], m_mem[m_pc[7:0]], m_pc);
					m_pc = m_pc + 16'd1;
				end
				2'b10: alu_step(op[2:0]);
				default: begin
					if (op[5]) begin
						if (m_flags[op[4:3]] ^ op[2])
							m_pc = m_ar; // Taken compare
					end else if (op[2:0] == 3'b001) begin
						done = 1'b1;
					end else if (op[2:0] == 3'b010) begin
						m_ar = m_ar + 16'd1;
					end
				end
			endcase
			steps++;
		end
		require(done, $sformatf("Model of program %0d never reached HLT", prog));
	endtask

	task automatic load_and_start();
		@(posedge clk);
		reset <= 1'b1;
		for (int i = 0; i < 256; i++) begin
			@(posedge clk);
			load_we   <= 1'b1;
			load_addr <= 8'(i);
			load_data <= img[i];
		end
		@(posedge clk);
		load_we <= 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		check_value($sformatf("program %0d out_port in reset", prog), 0, int'(out_port));
		require(!out_strobe && !halted, "out_strobe or halted is high during reset");
		@(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic watch_port();
		if (out_strobe) begin
			require(seen < exp_q.size(),
				$sformatf("Program %0d wrote the port more often than expected", prog));
			check_value($sformatf("program %0d port write %0d", prog, seen),
				int'(exp_q[seen]), int'(out_port));
			seen++;
		end
	endtask

	task automatic wait_for_halt();
		int cycles;
		cycles = 0;
		seen = 0;
		while (!halted) begin
			@(negedge clk);
			watch_port();
			cycles++;
			require(cycles < 2000,
				$sformatf("Timed out waiting for halted in program %0d", prog));
		end
	endtask

	task automatic check_after_halt();
		repeat (10) begin
			@(negedge clk);
			require(!out_strobe,
				$sformatf("out_strobe pulsed after HLT in program %0d", prog));
		end
		check_value($sformatf("program %0d port write count", prog), exp_q.size(), seen);
		for (int i = 0; i < 256; i++)
			check_value($sformatf("program %0d ram[%0d]", prog, i),
				int'(m_mem[i]), int'(UUT.u_memory.ram[i])); // Wrapped INC_AR stores
	endtask

	initial begin
		seed      = 32'hd80bbf5d;
		reset     = 1'b1;
		load_we   = 1'b0;
		load_addr = '0;
		load_data = '0;
		for (prog = 0; prog < 8; prog++) begin
			build_program();
			run_model();
			load_and_start();
			wait_for_halt();
			check_after_halt();
		end
		$display("Test completed successfully");
		$finish;
	end

endmodule
